/* Bender.yml */
package:
  name: fixed_weight

sources:
  - files:
      - hw/fw_pkg.sv
      - hw/loc_mem_if.sv
      - hw/mod_reducer.sv
      - hw/shake_feeder.sv
      - hw/location_sampler.sv
      - hw/duplicate_fixer.sv
      - hw/loc_mem_arbiter.sv
      - hw/fixed_weight_top.sv
  - target: test
    files:
      - verif/fixed_weight_assertions.sv
      - verif/fixed_weight_tb.sv

/* hw/duplicate_fixer.sv */
`timescale 1ns/10ps
`default_nettype none

module duplicate_fixer #(
    parameter int WEIGHT = 75
) (
    input  logic         clk,
    input  logic         rst,
    input  logic         load_done,
    output logic         done,
    loc_mem_if.requester mem
);
    localparam int IDX_W = $clog2(WEIGHT);
    localparam int LOC_W = $bits(mem.wdata);

    typedef enum logic [2:0] {
        S_IDLE,
        S_RD_I,
        S_CAP_I,
        S_RD_J,
        S_CMP,
        S_WR,
        S_NEXT
    } state_e;

    state_e           state;
    logic [IDX_W-1:0] idx_i;
    logic [IDX_W-1:0] idx_j;
    logic [LOC_W-1:0] loc_i;

    assign mem.req   = (state == S_RD_I) || (state == S_RD_J) || (state == S_WR);
    assign mem.we    = (state == S_WR);
    assign mem.addr  = (state == S_RD_J) ? idx_j : idx_i;
    // a repeated location is replaced by its own index
    assign mem.wdata = LOC_W'(idx_i);

    always_ff @(posedge clk) begin
        if (state == S_CAP_I) begin
            loc_i <= mem.rdata;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= S_IDLE;
            done  <= 1'b0;
            idx_i <= '0;
            idx_j <= '0;
        end else begin
            done <= 1'b0;
            case (state)
                S_IDLE: begin
                    if (load_done) begin
                        idx_i <= IDX_W'(WEIGHT - 2);
                        state <= S_RD_I;
                    end
                end
                S_RD_I: begin
                    if (mem.gnt) begin
                        state <= S_CAP_I;
                    end
                end
                S_CAP_I: begin
                    idx_j <= idx_i + 1'b1;
                    state <= S_RD_J;
                end
                S_RD_J: begin
                    if (mem.gnt) begin
                        state <= S_CMP;
                    end
                end
                S_CMP: begin
                    // first match ends the inner scan
                    if (mem.rdata == loc_i) begin
                        state <= S_WR;
                    end else if (idx_j == IDX_W'(WEIGHT - 1)) begin
                        state <= S_NEXT;
                    end else begin
                        idx_j <= idx_j + 1'b1;
                        state <= S_RD_J;
                    end
                end
                S_WR: begin
                    if (mem.gnt) begin
                        state <= S_NEXT;
                    end
                end
                default: begin
                    if (idx_i == '0) begin
                        done  <= 1'b1;
                        state <= S_IDLE;
                    end else begin
                        idx_i <= idx_i - 1'b1;
                        state <= S_RD_I;
                    end
                end
            endcase
        end
    end

endmodule

`default_nettype wire

/* hw/fixed_weight_top.sv */
`timescale 1ns/10ps
`default_nettype none

module fixed_weight_top #(
    parameter int N      = 17669,
    parameter int WEIGHT = 75
) (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      start,
    input  logic                      seed_wen,
    input  fw_pkg::seed_addr_t        seed_addr,
    input  fw_pkg::word_t             seed_word,
    output fw_pkg::word_t             shake_din,
    output logic                      shake_din_valid,
    input  fw_pkg::word_t             shake_dout,
    input  logic                      shake_dout_valid,
    output logic                      shake_dout_ready,
    input  logic                      rd_en,
    input  logic [$clog2(WEIGHT)-1:0] rd_addr,
    output logic [$clog2(N)-1:0]      error_loc,
    output logic                      done
);
    localparam int LOC_W = $clog2(N);
    localparam int IDX_W = $clog2(WEIGHT);

    logic load_done;

    loc_mem_if #(.ADDR_W(IDX_W), .DATA_W(LOC_W)) smp_mem ();
    loc_mem_if #(.ADDR_W(IDX_W), .DATA_W(LOC_W)) fix_mem ();

    shake_feeder #(
        .WEIGHT(WEIGHT)
    ) feeder_i (
        .clk            (clk),
        .rst            (rst),
        .start          (start),
        .seed_wen       (seed_wen),
        .seed_addr      (seed_addr),
        .seed_word      (seed_word),
        .shake_din      (shake_din),
        .shake_din_valid(shake_din_valid)
    );

    location_sampler #(
        .N     (N),
        .WEIGHT(WEIGHT)
    ) sampler_i (
        .clk             (clk),
        .rst             (rst),
        .start           (start),
        .shake_dout      (shake_dout),
        .shake_dout_valid(shake_dout_valid),
        .shake_dout_ready(shake_dout_ready),
        .load_done       (load_done),
        .mem             (smp_mem.requester)
    );

    duplicate_fixer #(
        .WEIGHT(WEIGHT)
    ) fixer_i (
        .clk      (clk),
        .rst      (rst),
        .load_done(load_done),
        .done     (done),
        .mem      (fix_mem.requester)
    );

    loc_mem_arbiter #(
        .N     (N),
        .WEIGHT(WEIGHT)
    ) arbiter_i (
        .clk      (clk),
        .rst      (rst),
        .rd_en    (rd_en),
        .rd_addr  (rd_addr),
        .error_loc(error_loc),
        .fix_port (fix_mem.arbiter),
        .smp_port (smp_mem.arbiter)
    );

endmodule

`default_nettype wire

/* hw/fw_pkg.sv */
`default_nettype none

package fw_pkg;

    // one SHAKE input or output word
    typedef logic [31:0] word_t;

    // secret seed geometry, 320 bits
    localparam int SEED_WORDS = 10;
    typedef logic [3:0] seed_addr_t;

    // SHAKE command words
    localparam word_t SEED_LEN_WORD   = 32'h8000_0148;
    localparam word_t DOMAIN_SEP_WORD = 32'h0000_0002;
    // squeeze command, output bit count is added on top
    localparam word_t SQUEEZE_BASE    = 32'h4000_0000;

    // feeder output select
    typedef enum logic [1:0] {
        FEED_SQUEEZE,
        FEED_LENGTH,
        FEED_SEED,
        FEED_DOMAIN
    } feed_sel_e;

endpackage

`default_nettype wire

/* hw/loc_mem_arbiter.sv */
`timescale 1ns/10ps
`default_nettype none

module loc_mem_arbiter #(
    parameter int N      = 17669,
    parameter int WEIGHT = 75
) (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      rd_en,
    input  logic [$clog2(WEIGHT)-1:0] rd_addr,
    output logic [$clog2(N)-1:0]      error_loc,
    loc_mem_if.arbiter                fix_port,
    loc_mem_if.arbiter                smp_port
);
    localparam int LOC_W = $clog2(N);
    localparam int IDX_W = $clog2(WEIGHT);

    typedef enum logic [1:0] {OWN_NONE, OWN_FIX, OWN_SMP, OWN_EXT} owner_e;

    logic [LOC_W-1:0] loc_mem [WEIGHT];
    logic [LOC_W-1:0] rd_q;
    owner_e           owner_d;
    owner_e           owner_q;
    logic [IDX_W-1:0] addr;
    logic             we;
    logic [LOC_W-1:0] wdata;

    // fixed priority: fixer, sampler, external readout
    always_comb begin
        fix_port.gnt = fix_port.req;
        smp_port.gnt = smp_port.req && !fix_port.req;
        if (fix_port.req) begin
            owner_d = OWN_FIX;
            addr    = fix_port.addr;
            we      = fix_port.we;
            wdata   = fix_port.wdata;
        end else if (smp_port.req) begin
            owner_d = OWN_SMP;
            addr    = smp_port.addr;
            we      = smp_port.we;
            wdata   = smp_port.wdata;
        end else begin
            owner_d = rd_en ? OWN_EXT : OWN_NONE;
            addr    = rd_addr;
            we      = 1'b0;
            wdata   = '0;
        end
    end

    // single port, one access per cycle
    always_ff @(posedge clk) begin
        if (owner_d != OWN_NONE) begin
            if (we) begin
                loc_mem[addr] <= wdata;
            end else begin
                rd_q <= loc_mem[addr];
            end
        end
    end

    // remember who owns the read data of the next cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            owner_q <= OWN_NONE;
        end else begin
            owner_q <= we ? OWN_NONE : owner_d;
        end
    end

    assign fix_port.rdata = (owner_q == OWN_FIX) ? rd_q : '0;
    assign smp_port.rdata = (owner_q == OWN_SMP) ? rd_q : '0;
    assign error_loc      = (owner_q == OWN_EXT) ? rd_q : '0;

endmodule

`default_nettype wire

/* hw/loc_mem_if.sv */
`timescale 1ns/10ps
`default_nettype none

interface loc_mem_if #(
    parameter int ADDR_W = 7,
    parameter int DATA_W = 15
);
    logic              req;
    logic              we;
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] wdata;
    logic              gnt;
    // valid the cycle after a granted read
    logic [DATA_W-1:0] rdata;

    modport requester (output req, we, addr, wdata, input gnt, rdata);
    modport arbiter (input req, we, addr, wdata, output gnt, rdata);

endinterface

`default_nettype wire

/* hw/location_sampler.sv */
`timescale 1ns/10ps
`default_nettype none

module location_sampler #(
    parameter int N      = 17669,
    parameter int WEIGHT = 75
) (
    input  logic          clk,
    input  logic          rst,
    input  logic          start,
    input  fw_pkg::word_t shake_dout,
    input  logic          shake_dout_valid,
    output logic          shake_dout_ready,
    output logic          load_done,
    loc_mem_if.requester  mem
);
    import fw_pkg::*;

    localparam int LOC_W = $clog2(N);
    localparam int IDX_W = $clog2(WEIGHT);

    typedef enum logic [1:0] {S_IDLE, S_TAKE, S_REDUCE, S_WRITE} state_e;

    state_e           state;
    word_t            word_q;
    logic [IDX_W-1:0] idx;
    logic [LOC_W-1:0] n_minus_i;
    logic             red_start;
    logic             red_done;
    logic [LOC_W-1:0] red_rem;

    mod_reducer #(
        .N(N)
    ) reducer_i (
        .clk      (clk),
        .rst      (rst),
        .start    (red_start),
        .dividend (word_q),
        .divisor  (n_minus_i),
        .done     (red_done),
        .remainder(red_rem)
    );

    // location_i = i + (r_i mod (N - i)), written at address i
    assign mem.req   = (state == S_WRITE);
    assign mem.we    = 1'b1;
    assign mem.addr  = idx;
    assign mem.wdata = LOC_W'(idx) + red_rem;

    always_ff @(posedge clk) begin
        if (state == S_TAKE && shake_dout_valid && shake_dout_ready) begin
            word_q <= shake_dout;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state            <= S_IDLE;
            shake_dout_ready <= 1'b0;
            load_done        <= 1'b0;
            red_start        <= 1'b0;
            idx              <= '0;
            n_minus_i        <= LOC_W'(N);
        end else begin
            load_done <= 1'b0;
            red_start <= 1'b0;
            case (state)
                S_IDLE: begin
                    if (start) begin
                        state            <= S_TAKE;
                        shake_dout_ready <= 1'b1;
                        idx              <= '0;
                        n_minus_i        <= LOC_W'(N);
                    end
                end
                S_TAKE: begin
                    if (shake_dout_valid && shake_dout_ready) begin
                        shake_dout_ready <= 1'b0;
                        red_start        <= 1'b1;
                        state            <= S_REDUCE;
                    end
                end
                S_REDUCE: begin
                    if (red_done) begin
                        state <= S_WRITE;
                    end
                end
                default: begin
                    // wait for the arbiter, then take the next word
                    if (mem.gnt) begin
                        if (idx == IDX_W'(WEIGHT - 1)) begin
                            state     <= S_IDLE;
                            load_done <= 1'b1;
                        end else begin
                            idx              <= idx + 1'b1;
                            n_minus_i        <= n_minus_i - 1'b1;
                            shake_dout_ready <= 1'b1;
                            state            <= S_TAKE;
                        end
                    end
                end
            endcase
        end
    end

endmodule

`default_nettype wire

/* hw/mod_reducer.sv */
`timescale 1ns/10ps
`default_nettype none

module mod_reducer #(
    parameter int N = 17669
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 start,
    input  fw_pkg::word_t        dividend,
    input  logic [$clog2(N)-1:0] divisor,
    output logic                 done,
    output logic [$clog2(N)-1:0] remainder
);
    import fw_pkg::*;

    localparam int LOC_W = $clog2(N);

    word_t          shift_q;
    logic [4:0]     bit_cnt;
    logic           busy;
    logic [LOC_W:0] trial;

    // partial remainder with the next dividend bit shifted in
    assign trial = {remainder, shift_q[31]};

    always_ff @(posedge clk) begin
        if (rst) begin
            busy    <= 1'b0;
            done    <= 1'b0;
            bit_cnt <= '0;
        end else begin
            done <= 1'b0;
            if (!busy) begin
                if (start) begin
                    busy    <= 1'b1;
                    bit_cnt <= '0;
                end
            end else begin
                bit_cnt <= bit_cnt + 1'b1;
                // 32 steps after the load cycle
                if (bit_cnt == 5'd31) begin
                    busy <= 1'b0;
                    done <= 1'b1;
                end
            end
        end
    end

    // restoring shift and subtract
    always_ff @(posedge clk) begin
        if (!busy && start) begin
            shift_q   <= dividend;
            remainder <= '0;
        end else if (busy) begin
            shift_q <= {shift_q[30:0], 1'b0};
            if (trial >= {1'b0, divisor}) begin
                remainder <= LOC_W'(trial - {1'b0, divisor});
            end else begin
                remainder <= trial[LOC_W-1:0];
            end
        end
    end

endmodule

`default_nettype wire

/* hw/shake_feeder.sv */
`timescale 1ns/10ps
`default_nettype none

module shake_feeder #(
    parameter int WEIGHT = 75
) (
    input  logic               clk,
    input  logic               rst,
    input  logic               start,
    input  logic               seed_wen,
    input  fw_pkg::seed_addr_t seed_addr,
    input  fw_pkg::word_t      seed_word,
    output fw_pkg::word_t      shake_din,
    output logic               shake_din_valid
);
    import fw_pkg::*;

    // 32 bits per location, rounded up to whole 64-bit lanes
    localparam int    SQUEEZE_BITS = ((32 * WEIGHT + 63) / 64) * 64;
    localparam word_t SQUEEZE_WORD = SQUEEZE_BASE + word_t'(SQUEEZE_BITS);

    word_t      seed_mem [SEED_WORDS];
    feed_sel_e  sel;
    seed_addr_t seed_ptr;
    logic       busy;

    always_ff @(posedge clk) begin
        if (seed_wen) begin
            seed_mem[seed_addr] <= seed_word;
        end
    end

    // strobe, then one idle cycle in which the next word is selected
    always_ff @(posedge clk) begin
        if (rst) begin
            busy            <= 1'b0;
            sel             <= FEED_SQUEEZE;
            seed_ptr        <= '0;
            shake_din_valid <= 1'b0;
        end else if (!busy) begin
            if (start) begin
                busy            <= 1'b1;
                sel             <= FEED_SQUEEZE;
                seed_ptr        <= '0;
                shake_din_valid <= 1'b1;
            end
        end else if (shake_din_valid) begin
            shake_din_valid <= 1'b0;
        end else begin
            case (sel)
                FEED_SQUEEZE: begin
                    sel             <= FEED_LENGTH;
                    shake_din_valid <= 1'b1;
                end
                FEED_LENGTH: begin
                    sel             <= FEED_SEED;
                    shake_din_valid <= 1'b1;
                end
                FEED_SEED: begin
                    if (seed_ptr == seed_addr_t'(SEED_WORDS - 1)) begin
                        sel <= FEED_DOMAIN;
                    end else begin
                        seed_ptr <= seed_ptr + 1'b1;
                    end
                    shake_din_valid <= 1'b1;
                end
                default: begin
                    // domain separator was the last word
                    busy <= 1'b0;
                end
            endcase
        end
    end

    always_comb begin
        case (sel)
            FEED_SQUEEZE: shake_din = SQUEEZE_WORD;
            FEED_LENGTH:  shake_din = SEED_LEN_WORD;
            FEED_SEED:    shake_din = seed_mem[seed_ptr];
            default:      shake_din = DOMAIN_SEP_WORD;
        endcase
    end

endmodule

`default_nettype wire

/* src.f */
hw/fw_pkg.sv
hw/loc_mem_if.sv
hw/mod_reducer.sv
hw/shake_feeder.sv
hw/location_sampler.sv
hw/duplicate_fixer.sv
hw/loc_mem_arbiter.sv
hw/fixed_weight_top.sv
verif/fixed_weight_assertions.sv
verif/fixed_weight_tb.sv

/* verif/fixed_weight_assertions.sv */
`timescale 1ns/10ps
`default_nettype none

module fixed_weight_assertions (
    input logic clk,
    input logic rst,
    input logic done,
    input logic shake_din_valid,
    input logic shake_dout_valid,
    input logic shake_dout_ready
);

    // done is a single-cycle pulse
    done_pulse: assert property (@(posedge clk) disable iff (rst) done |=> !done)
        else $error("done high for two cycles in a row");

    // one idle cycle after every feed strobe
    feed_strobe: assert property (@(posedge clk) disable iff (rst)
        shake_din_valid |=> !shake_din_valid)
        else $error("shake_din_valid high for two cycles in a row");

    ready_drop: assert property (@(posedge clk) disable iff (rst)
        shake_dout_valid && shake_dout_ready |=> !shake_dout_ready)
        else $error("shake_dout_ready still high after an accepted word");

endmodule

bind fixed_weight_top fixed_weight_assertions assertions_i (
    .clk             (clk),
    .rst             (rst),
    .done            (done),
    .shake_din_valid (shake_din_valid),
    .shake_dout_valid(shake_dout_valid),
    .shake_dout_ready(shake_dout_ready)
);

`default_nettype wire

/* verif/fixed_weight_tb.sv */
`timescale 1ns/10ps
`default_nettype none

module fixed_weight_tb;
    import fw_pkg::*;

    localparam int N        = 61;
    localparam int WEIGHT   = 16;
    localparam int LOC_W    = $clog2(N);
    localparam int IDX_W    = $clog2(WEIGHT);
    localparam int FEED_LEN = SEED_WORDS + 3;

    // test ids
    localparam int T_RESET = 0;
    localparam int T_FEED  = 1;
    localparam int T_LOC   = 2;
    localparam int T_BP    = 3;
    localparam int T_RUN2  = 4;

    logic             clk = 1'b0;
    logic             rst;
    logic             start;
    logic             seed_wen;
    seed_addr_t       seed_addr;
    word_t            seed_word;
    word_t            shake_din;
    logic             shake_din_valid;
    word_t            shake_dout;
    logic             shake_dout_valid;
    logic             shake_dout_ready;
    logic             rd_en;
    logic [IDX_W-1:0] rd_addr;
    logic [LOC_W-1:0] error_loc;
    logic             done;

    word_t lcg_state = 32'hf610_f034;
    int    errors = 0;
    int    checks = 0;
    int    test_errors [5] = '{default: 0};
    int    accepted = 0;
    word_t seed_q [SEED_WORDS];
    word_t rand_q [WEIGHT];
    int    gap_q [WEIGHT];
    int    model_loc [WEIGHT];

    fixed_weight_top #(
        .N     (N),
        .WEIGHT(WEIGHT)
    ) dut_i (
        .clk             (clk),
        .rst             (rst),
        .start           (start),
        .seed_wen        (seed_wen),
        .seed_addr       (seed_addr),
        .seed_word       (seed_word),
        .shake_din       (shake_din),
        .shake_din_valid (shake_din_valid),
        .shake_dout      (shake_dout),
        .shake_dout_valid(shake_dout_valid),
        .shake_dout_ready(shake_dout_ready),
        .rd_en           (rd_en),
        .rd_addr         (rd_addr),
        .error_loc       (error_loc),
        .done            (done)
    );

    always #2 clk = ~clk;

    // words taken by the DUT, counted at the handshake edge
    always @(posedge clk) begin
        if (shake_dout_valid && shake_dout_ready) begin
            accepted++;
        end
    end

    function automatic word_t lcg_next(input word_t s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic next_rand(output word_t r);
        lcg_state = lcg_next(lcg_state);
        r = lcg_state;
    endtask

    task automatic check(input int id, input string name, input word_t got, input word_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            test_errors[id]++;
            $display("ERR %0t %s got %0h expected %0h", $time, name, got, exp);
        end
    endtask

    task automatic timeout_error(input int id, input string what);
        errors++;
        test_errors[id]++;
        $display("%0t: timed out waiting for %s", $time, what);
    endtask

    task automatic report(input int id, input string name);
        if (test_errors[id] == 0) begin
            $display("test %s: ok", name);
        end else begin
            $display("test %s: %0d errors", name, test_errors[id]);
        end
    endtask

    task automatic load_seed();
        for (int k = 0; k < SEED_WORDS; k++) begin
            next_rand(seed_q[k]);
            @(negedge clk);
            seed_wen  = 1'b1;
            seed_addr = seed_addr_t'(k);
            seed_word = seed_q[k];
        end
        @(negedge clk);
        seed_wen = 1'b0;
    endtask

    // reference model: sampling rule, then backward duplicate scan
    task automatic build_model();
        word_t r;
        for (int i = 0; i < WEIGHT; i++) begin
            next_rand(rand_q[i]);
            next_rand(r);
            gap_q[i] = int'(r[31:30]);
            model_loc[i] = i + int'(rand_q[i] % word_t'(N - i));
        end
        for (int i = WEIGHT - 2; i >= 0; i--) begin
            for (int j = i + 1; j < WEIGHT; j++) begin
                if (model_loc[i] == model_loc[j]) begin
                    model_loc[i] = i;
                    break;
                end
            end
        end
    endtask

    task automatic watch_feed(input int id);
        word_t expected [FEED_LEN];
        int    k;
        int    cyc;
        int    bits;
        // one 32-bit word per location, padded to whole 64-bit lanes
        bits = 32 * WEIGHT;
        if (bits % 64 != 0) begin
            bits += 32;
        end
        expected[0] = SQUEEZE_BASE + word_t'(bits);
        expected[1] = SEED_LEN_WORD;
        for (int s = 0; s < SEED_WORDS; s++) begin
            expected[s + 2] = seed_q[s];
        end
        expected[FEED_LEN - 1] = DOMAIN_SEP_WORD;
        k = 0;
        cyc = 0;
        while (k < FEED_LEN && cyc < 200) begin
            @(negedge clk);
            cyc++;
            if (shake_din_valid) begin
                check(id, "shake_din", shake_din, expected[k]);
                check(id, "shake_din_valid cycle", cyc, 1 + 2 * k);
                k++;
            end
        end
        if (k < FEED_LEN) begin
            timeout_error(id, "all shake_din strobes");
        end
    endtask

    // SHAKE output model, each word held until consumed
    task automatic drive_shake(input int id);
        logic rdy;
        int   wait_cyc;
        accepted = 0;
        for (int i = 0; i < WEIGHT; i++) begin
            repeat (gap_q[i]) @(negedge clk);
            shake_dout_valid = 1'b1;
            shake_dout = rand_q[i];
            // ready seen now holds through the next rising edge
            rdy = shake_dout_ready;
            wait_cyc = 0;
            while (!rdy && wait_cyc < 300) begin
                @(negedge clk);
                wait_cyc++;
                check(id, "done", done, 1'b0);
                rdy = shake_dout_ready;
            end
            if (!rdy) begin
                timeout_error(id, "shake_dout_ready");
                return;
            end
            @(negedge clk);
            shake_dout_valid = 1'b0;
            check(id, "shake_dout_ready", shake_dout_ready, 1'b0);
        end
        // surplus word must stay unconsumed until done
        shake_dout_valid = 1'b1;
        next_rand(shake_dout);
        wait_cyc = 0;
        while (!done && wait_cyc < 3000) begin
            @(negedge clk);
            wait_cyc++;
            check(id, "shake_dout_ready", shake_dout_ready, 1'b0);
        end
        shake_dout_valid = 1'b0;
        if (!done) begin
            timeout_error(id, "done");
        end else begin
            check(id, "words consumed", accepted, WEIGHT);
        end
    endtask

    task automatic read_back(input int id);
        logic [LOC_W-1:0] got [WEIGHT];
        for (int a = 0; a <= WEIGHT; a++) begin
            @(negedge clk);
            if (a > 0) begin
                got[a - 1] = error_loc;
                check(id, "error_loc", error_loc, model_loc[a - 1]);
            end
            rd_en   = (a < WEIGHT);
            rd_addr = IDX_W'(a);
        end
        for (int a = 0; a < WEIGHT; a++) begin
            check(id, "error_loc below N", got[a] < N, 1'b1);
            for (int b = a + 1; b < WEIGHT; b++) begin
                check(id, "error_loc distinct", got[a] != got[b], 1'b1);
            end
        end
    endtask

    task automatic run_vector(input int feed_id, input int loc_id, input int bp_id);
        load_seed();
        build_model();
        @(negedge clk);
        start = 1'b1;
        fork
            begin
                @(negedge clk);
                start = 1'b0;
            end
            watch_feed(feed_id);
            drive_shake(bp_id);
        join
        read_back(loc_id);
    endtask

    initial begin
        rst              = 1'b1;
        start            = 1'b0;
        seed_wen         = 1'b0;
        seed_addr        = '0;
        seed_word        = '0;
        shake_dout       = '0;
        shake_dout_valid = 1'b0;
        rd_en            = 1'b0;
        rd_addr          = '0;
        repeat (8) @(negedge clk);
        rst = 1'b0;
        @(negedge clk);
        check(T_RESET, "done", done, 1'b0);
        check(T_RESET, "shake_din_valid", shake_din_valid, 1'b0);
        check(T_RESET, "shake_dout_ready", shake_dout_ready, 1'b0);
        report(T_RESET, "reset");

        run_vector(T_FEED, T_LOC, T_BP);
        report(T_FEED, "feed sequence");
        report(T_LOC, "locations");
        report(T_BP, "back-pressure");

        // new seed and new words
        run_vector(T_RUN2, T_RUN2, T_RUN2);
        report(T_RUN2, "second run");

        $display("5 tests, %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
